/* source/dm_macros.svh */
`ifndef DM_MACROS_SVH
`define DM_MACROS_SVH

// widths fixed by the debug spec
`define DM_XLEN                         32
`define DM_DMI_ADDR_W                   7
`define DM_REGNO_W                      16

// dmi opcodes, 3 is reserved
`define DM_OP_NOP                       2'd0
`define DM_OP_READ                      2'd1
`define DM_OP_WRITE                     2'd2

// debug register map
`define DM_ADDR_DATA0                   7'h04
`define DM_ADDR_DATA1                   7'h05
`define DM_ADDR_DMCONTROL               7'h10
`define DM_ADDR_DMSTATUS                7'h11
`define DM_ADDR_ABSTRACTCS              7'h16
`define DM_ADDR_COMMAND                 7'h17

// abstract command types
`define DM_CMD_ACCESS_REG               8'd0
`define DM_CMD_ACCESS_MEM               8'd2

// status bit positions
`define DM_DMSTATUS_ALLHALTED_BIT       9
`define DM_DMSTATUS_ALLRUNNING_BIT      11
`define DM_DMSTATUS_ALLRESUMEACK_BIT    17
`define DM_ABSTRACTCS_BUSY_BIT          12

`endif

/* source/dm_pkg.sv */
`default_nettype none

`include "dm_macros.svh"

package dm_pkg;

    //////////////////////////////////////////////////////////////////////
    // dmi transport
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0]                    op;
        logic [`DM_DMI_ADDR_W-1:0]     addr;
        logic [`DM_XLEN-1:0]           data;
    } dmi_req_t;

    typedef struct packed {
        logic [`DM_XLEN-1:0]           data;
        logic                          error;
    } dmi_resp_t;

    //////////////////////////////////////////////////////////////////////
    // debug registers
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                          haltreq;
        logic                          resumereq;
        logic [29:1]                   reserved;
        logic                          dmactive;
    } dmcontrol_t;

    typedef struct packed {
        logic [7:0]                    cmdtype;
        logic [23:18]                  reserved;
        logic                          transfer;
        logic                          write;
        logic [`DM_REGNO_W-1:0]        regno;
    } access_reg_t;

    typedef struct packed {
        logic [7:0]                    cmdtype;
        logic [23:17]                  reserved_hi;
        logic                          write;
        logic [15:0]                   reserved_lo;
    } access_mem_t;

    // one command word, meaning picked by cmdtype
    typedef union packed {
        access_reg_t                   reg_access;
        access_mem_t                   mem_access;
    } dm_command_u;

    //////////////////////////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                          halted;
        logic                          running;
        logic                          resumeack;
    } hart_status_t;

    typedef struct packed {
        logic                          en;
        logic                          we;
        logic [`DM_REGNO_W-1:0]        addr;
        logic [`DM_XLEN-1:0]           wdata;
    } reg_xfer_t;

    typedef struct packed {
        logic                          valid;
        logic [`DM_XLEN-1:0]           data;
    } data0_upd_t;

    typedef enum logic [1:0] {
        NORMAL,
        HALTING,
        HALTED,
        RESUMING
    } run_state_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        TRANSFER,
        MEM_READ,
        DONE
    } cmd_state_e;

endpackage

`default_nettype wire

/* source/dm_dmi_regs.sv */
`default_nettype none

`include "dm_macros.svh"

module dm_dmi_regs (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // dmi request and response
    input  logic                   dmi_req_valid_i,
    input  dm_pkg::dmi_req_t       dmi_req_i,
    output logic                   dmi_req_ready_o,
    output logic                   dmi_resp_valid_o,
    output dm_pkg::dmi_resp_t      dmi_resp_o,

    // status from the run control and the command engine
    input  dm_pkg::hart_status_t   hart_status_i,
    input  logic                   clear_run_req_i,
    input  logic                   busy_i,
    input  dm_pkg::data0_upd_t     data0_upd_i,

    // register contents
    output dm_pkg::dmcontrol_t     dmcontrol_o,
    output dm_pkg::dm_command_u    command_o,
    output logic [`DM_XLEN-1:0]    data0_o,
    output logic [`DM_XLEN-1:0]    data1_o,
    output logic                   cmd_start_o
);

    import dm_pkg::*;

    logic                  accept;
    logic                  is_read;
    logic                  is_write;
    logic                  op_bad;
    logic                  rd_ok;
    logic                  wr_ok;
    logic                  arg_locked;
    logic                  hit_dmcontrol;
    logic                  hit_command;
    logic                  hit_data0;
    logic                  hit_data1;
    logic                  wr_dmcontrol;
    logic                  wr_command;
    logic                  wr_data0;
    logic                  wr_data1;
    logic [`DM_XLEN-1:0]   dmstatus;
    logic [`DM_XLEN-1:0]   abstractcs;
    logic [`DM_XLEN-1:0]   rd_data;
    dmi_resp_t             resp_d;
    dmcontrol_t            dmcontrol_d;

    // one request in flight, ready drops while the response goes out
    assign dmi_req_ready_o = !dmi_resp_valid_o;
    assign accept          = dmi_req_valid_i && dmi_req_ready_o;

    //////////////////////////////////////////////////////////////////////
    // status words and read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dmstatus = '0;
        dmstatus[`DM_DMSTATUS_ALLHALTED_BIT]    = hart_status_i.halted;
        dmstatus[`DM_DMSTATUS_ALLRUNNING_BIT]   = hart_status_i.running;
        dmstatus[`DM_DMSTATUS_ALLRESUMEACK_BIT] = hart_status_i.resumeack;

        abstractcs = '0;
        abstractcs[`DM_ABSTRACTCS_BUSY_BIT] = busy_i;

        rd_ok = 1'b1;
        case (dmi_req_i.addr)
            `DM_ADDR_DMSTATUS:   rd_data = dmstatus;
            `DM_ADDR_ABSTRACTCS: rd_data = abstractcs;
            `DM_ADDR_DATA0:      rd_data = data0_o;
            default: begin
                rd_data = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // legality checks
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        is_read  = dmi_req_i.op == `DM_OP_READ;
        is_write = dmi_req_i.op == `DM_OP_WRITE;
        op_bad   = !is_read && !is_write && (dmi_req_i.op != `DM_OP_NOP);

        hit_dmcontrol = dmi_req_i.addr == `DM_ADDR_DMCONTROL;
        hit_command   = dmi_req_i.addr == `DM_ADDR_COMMAND;
        hit_data0     = dmi_req_i.addr == `DM_ADDR_DATA0;
        hit_data1     = dmi_req_i.addr == `DM_ADDR_DATA1;

        // command arguments only move while halted and idle
        arg_locked = !hart_status_i.halted || busy_i;
        wr_ok = hit_dmcontrol || ((hit_command || hit_data0 || hit_data1) && !arg_locked);

        wr_dmcontrol = accept && is_write && hit_dmcontrol;
        wr_command   = accept && is_write && hit_command && !arg_locked;
        wr_data0     = accept && is_write && hit_data0 && !arg_locked;
        wr_data1     = accept && is_write && hit_data1 && !arg_locked;

        resp_d.error = op_bad || (is_read && !rd_ok) || (is_write && !wr_ok);
        resp_d.data  = (is_read && rd_ok) ? rd_data : '0;
    end

    // next dmcontrol, run requests drop once the resume is under way
    always_comb begin
        dmcontrol_d = dmcontrol_o;
        if (wr_dmcontrol) begin
            dmcontrol_d          = dmi_req_i.data;
            dmcontrol_d.reserved = '0;
        end else if (clear_run_req_i) begin
            dmcontrol_d.haltreq   = 1'b0;
            dmcontrol_d.resumereq = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            dmi_resp_valid_o <= 1'b0;
            dmi_resp_o       <= '0;
            dmcontrol_o      <= '0;
            command_o        <= '0;
            data0_o          <= '0;
            data1_o          <= '0;
            cmd_start_o      <= 1'b0;
        end else begin
            dmi_resp_valid_o <= accept;
            cmd_start_o      <= wr_command;
            dmcontrol_o      <= dmcontrol_d;
            if (accept) begin
                dmi_resp_o <= resp_d;
            end
            if (wr_command) begin
                command_o <= dmi_req_i.data;
            end
            // engine result wins over a dmi write
            if (data0_upd_i.valid) begin
                data0_o <= data0_upd_i.data;
            end else if (wr_data0) begin
                data0_o <= dmi_req_i.data;
            end
            if (wr_data1) begin
                data1_o <= dmi_req_i.data;
            end
        end
    end

    // a response is a single pulse
    a_resp_single : assert property (
        @(posedge clk_i) disable iff (!reset_i)
        dmi_resp_valid_o |=> !dmi_resp_valid_o
    ) else $error("dmi response held for two cycles");

endmodule

`default_nettype wire

/* source/dm_run_ctrl.sv */
`default_nettype none

module dm_run_ctrl (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  dm_pkg::dmcontrol_t    dmcontrol_i,
    input  logic                  busy_i,

    // hart handshake
    input  logic                  core_halt_ack_i,
    input  logic                  core_resume_ack_i,
    input  logic                  core_ebreak_i,
    output logic                  core_halt_req_o,
    output logic                  core_resume_req_o,

    output logic                  clear_run_req_o,
    output dm_pkg::hart_status_t  hart_status_o
);

    import dm_pkg::*;

    run_state_e  state_q;
    run_state_e  state_d;
    logic        resumeack_q;
    logic        halt_entry;

    //////////////////////////////////////////////////////////////////////
    // run control FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            NORMAL: begin
                if (dmcontrol_i.dmactive && (dmcontrol_i.haltreq || core_ebreak_i)) begin
                    state_d = HALTING;
                end
            end
            HALTING: begin
                if (core_halt_ack_i) begin
                    state_d = HALTED;
                end
            end
            HALTED: begin
                // no resume while a command is running
                if (dmcontrol_i.resumereq && !dmcontrol_i.haltreq && !busy_i) begin
                    state_d = RESUMING;
                end
            end
            RESUMING: begin
                if (core_resume_ack_i) begin
                    state_d = NORMAL;
                end
            end
            default: state_d = NORMAL;
        endcase
    end

    assign halt_entry = (state_q == NORMAL) && (state_d == HALTING);

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            state_q     <= NORMAL;
            resumeack_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // sticky until the next halt
            if (halt_entry) begin
                resumeack_q <= 1'b0;
            end else if ((state_q == RESUMING) && core_resume_ack_i) begin
                resumeack_q <= 1'b1;
            end
        end
    end

    // outputs
    assign core_halt_req_o   = (state_q == HALTING) || (state_q == HALTED);
    assign core_resume_req_o = state_q == RESUMING;
    assign clear_run_req_o   = state_q == RESUMING;

    assign hart_status_o.halted    = state_q == HALTED;
    assign hart_status_o.running   = state_q == NORMAL;
    assign hart_status_o.resumeack = resumeack_q;

    a_req_exclusive : assert property (
        @(posedge clk_i) disable iff (!reset_i)
        core_resume_req_o |-> !core_halt_req_o
    ) else $error("halt and resume requested together");

endmodule

`default_nettype wire

/* source/dm_abstract_cmd.sv */
`default_nettype none

`include "dm_macros.svh"

module dm_abstract_cmd (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  cmd_start_i,
    input  dm_pkg::dm_command_u   command_i,
    input  logic [`DM_XLEN-1:0]   data0_i,
    input  logic [`DM_XLEN-1:0]   data1_i,
    output logic                  busy_o,

    // hart register port
    output dm_pkg::reg_xfer_t     core_reg_o,
    input  logic [`DM_XLEN-1:0]   core_reg_rdata_i,

    // memory read port
    output logic                  mem_rd_en_o,
    output logic [`DM_XLEN-1:0]   mem_rd_addr_o,
    input  logic [`DM_XLEN-1:0]   mem_rd_data_i,

    output dm_pkg::data0_upd_t    data0_upd_o
);

    import dm_pkg::*;

    cmd_state_e   state_q;
    cmd_state_e   state_d;
    access_reg_t  reg_cmd;
    access_mem_t  mem_cmd;
    logic         is_reg;
    logic         is_mem;

    // same word, two views
    assign reg_cmd = command_i.reg_access;
    assign mem_cmd = command_i.mem_access;
    assign is_reg  = reg_cmd.cmdtype == `DM_CMD_ACCESS_REG;
    assign is_mem  = mem_cmd.cmdtype == `DM_CMD_ACCESS_MEM;

    //////////////////////////////////////////////////////////////////////
    // command sequencer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_start_i) begin
                    state_d = START;
                end
            end
            START: begin
                if (is_reg && reg_cmd.transfer) begin
                    state_d = TRANSFER;
                end else if (is_mem && !mem_cmd.write) begin
                    state_d = MEM_READ;
                end else begin
                    // no transfer, memory write or unknown type
                    state_d = DONE;
                end
            end
            TRANSFER: state_d = DONE;
            MEM_READ: state_d = DONE;
            DONE:     state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign busy_o = state_q != IDLE;

    // register transfer, read data comes back in the same cycle
    assign core_reg_o.en    = state_q == TRANSFER;
    assign core_reg_o.we    = reg_cmd.write;
    assign core_reg_o.addr  = reg_cmd.regno;
    assign core_reg_o.wdata = data0_i;

    assign mem_rd_en_o   = state_q == MEM_READ;
    assign mem_rd_addr_o = data1_i;

    // results land in data0
    assign data0_upd_o.valid = ((state_q == TRANSFER) && !reg_cmd.write) || mem_rd_en_o;
    assign data0_upd_o.data  = mem_rd_en_o ? mem_rd_data_i : core_reg_rdata_i;

    a_port_exclusive : assert property (
        @(posedge clk_i) disable iff (!reset_i)
        !(core_reg_o.en && mem_rd_en_o)
    ) else $error("register and memory ports enabled together");

    // the register block must hold commands back while busy
    a_start_idle : assert property (
        @(posedge clk_i) disable iff (!reset_i)
        cmd_start_i |-> !busy_o
    ) else $error("command started while busy");

endmodule

`default_nettype wire

/* source/dm_top.sv */
`default_nettype none

`include "dm_macros.svh"

module dm_top (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // dmi
    input  logic                  dmi_req_valid_i,
    input  dm_pkg::dmi_req_t      dmi_req_i,
    output logic                  dmi_req_ready_o,
    output logic                  dmi_resp_valid_o,
    output dm_pkg::dmi_resp_t     dmi_resp_o,

    // hart run control
    input  logic                  core_halt_ack_i,
    input  logic                  core_resume_ack_i,
    input  logic                  core_ebreak_i,
    output logic                  core_halt_req_o,
    output logic                  core_resume_req_o,

    // hart register transfer
    output dm_pkg::reg_xfer_t     core_reg_o,
    input  logic [`DM_XLEN-1:0]   core_reg_rdata_i,

    // data memory
    output logic                  mem_rd_en_o,
    output logic [`DM_XLEN-1:0]   mem_rd_addr_o,
    input  logic [`DM_XLEN-1:0]   mem_rd_data_i
);

    import dm_pkg::*;

    dmcontrol_t            dmcontrol;
    dm_command_u           command;
    logic [`DM_XLEN-1:0]   data0;
    logic [`DM_XLEN-1:0]   data1;
    logic                  cmd_start;
    logic                  busy;
    logic                  clear_run_req;
    hart_status_t          hart_status;
    data0_upd_t            data0_upd;

    dm_dmi_regs dm_dmi_regs_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dmi_req_valid_i  (dmi_req_valid_i),
        .dmi_req_i        (dmi_req_i),
        .dmi_req_ready_o  (dmi_req_ready_o),
        .dmi_resp_valid_o (dmi_resp_valid_o),
        .dmi_resp_o       (dmi_resp_o),
        .hart_status_i    (hart_status),
        .clear_run_req_i  (clear_run_req),
        .busy_i           (busy),
        .data0_upd_i      (data0_upd),
        .dmcontrol_o      (dmcontrol),
        .command_o        (command),
        .data0_o          (data0),
        .data1_o          (data1),
        .cmd_start_o      (cmd_start)
    );

    dm_run_ctrl dm_run_ctrl_inst (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .dmcontrol_i       (dmcontrol),
        .busy_i            (busy),
        .core_halt_ack_i   (core_halt_ack_i),
        .core_resume_ack_i (core_resume_ack_i),
        .core_ebreak_i     (core_ebreak_i),
        .core_halt_req_o   (core_halt_req_o),
        .core_resume_req_o (core_resume_req_o),
        .clear_run_req_o   (clear_run_req),
        .hart_status_o     (hart_status)
    );

    dm_abstract_cmd dm_abstract_cmd_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .cmd_start_i      (cmd_start),
        .command_i        (command),
        .data0_i          (data0),
        .data1_i          (data1),
        .busy_o           (busy),
        .core_reg_o       (core_reg_o),
        .core_reg_rdata_i (core_reg_rdata_i),
        .mem_rd_en_o      (mem_rd_en_o),
        .mem_rd_addr_o    (mem_rd_addr_o),
        .mem_rd_data_i    (mem_rd_data_i),
        .data0_upd_o      (data0_upd)
    );

endmodule

`default_nettype wire

/* bench/dm_clock_gen.sv */
`default_nettype none

module dm_clock_gen (
    output logic clk_o
);

    // 100 unit period, low for the first half
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* bench/dm_tb.sv */
`default_nettype none

`include "dm_macros.svh"

module dm_tb;

    import dm_pkg::*;

    localparam int WAIT_LIMIT = 32;

    logic                  clk_i;
    logic                  reset_i;
    logic                  dmi_req_valid_i;
    dmi_req_t              dmi_req_i;
    logic                  dmi_req_ready_o;
    logic                  dmi_resp_valid_o;
    dmi_resp_t             dmi_resp_o;
    logic                  core_halt_ack_i = 1'b0;
    logic                  core_resume_ack_i = 1'b0;
    logic                  core_ebreak_i;
    logic                  core_halt_req_o;
    logic                  core_resume_req_o;
    reg_xfer_t             core_reg_o;
    logic [`DM_XLEN-1:0]   core_reg_rdata_i = '0;
    logic                  mem_rd_en_o;
    logic [`DM_XLEN-1:0]   mem_rd_addr_o;
    logic [`DM_XLEN-1:0]   mem_rd_data_i = '0;

    integer                seed;
    integer                error_count;
    integer                check_count;
    logic                  timed_out;
    int                    halt_cycles = 0;
    int                    resume_cycles = 0;
    int                    reg_pulses;
    int                    mem_pulses;
    logic                  exp_we;
    logic [15:0]           exp_regno;
    logic [31:0]           exp_wdata;
    logic [31:0]           exp_mem_addr;
    logic [31:0]           reg_table [0:65535];
    logic [31:0]           rdata;
    logic                  err;
    logic [15:0]           regno;
    logic [31:0]           wval;
    logic [31:0]           maddr;

    dm_clock_gen clock_gen_inst (
        .clk_o (clk_i)
    );

    dm_top dm_top_inst (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .dmi_req_valid_i   (dmi_req_valid_i),
        .dmi_req_i         (dmi_req_i),
        .dmi_req_ready_o   (dmi_req_ready_o),
        .dmi_resp_valid_o  (dmi_resp_valid_o),
        .dmi_resp_o        (dmi_resp_o),
        .core_halt_ack_i   (core_halt_ack_i),
        .core_resume_ack_i (core_resume_ack_i),
        .core_ebreak_i     (core_ebreak_i),
        .core_halt_req_o   (core_halt_req_o),
        .core_resume_req_o (core_resume_req_o),
        .core_reg_o        (core_reg_o),
        .core_reg_rdata_i  (core_reg_rdata_i),
        .mem_rd_en_o       (mem_rd_en_o),
        .mem_rd_addr_o     (mem_rd_addr_o),
        .mem_rd_data_i     (mem_rd_data_i)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] mem_ref(input logic [31:0] addr);
        return (addr ^ 32'hA5A5_A5A5) + 32'd1;
    endfunction

    // data0 after a register read or a memory read
    function automatic logic [31:0] expected_data0(input logic is_mem, input logic [31:0] key);
        if (is_mem) begin
            return mem_ref(key);
        end
        return reg_table[key[15:0]];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // hart and memory models
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        // acks come two cycles after the request
        if (core_halt_req_o) begin
            if (halt_cycles >= 1) begin
                core_halt_ack_i <= 1'b1;
            end
            halt_cycles <= halt_cycles + 1;
        end else begin
            halt_cycles     <= 0;
            core_halt_ack_i <= 1'b0;
        end
        if (core_resume_req_o) begin
            if (resume_cycles >= 1) begin
                core_resume_ack_i <= 1'b1;
            end
            resume_cycles <= resume_cycles + 1;
        end else begin
            resume_cycles     <= 0;
            core_resume_ack_i <= 1'b0;
        end
        core_reg_rdata_i <= core_reg_o.en ? reg_table[core_reg_o.addr] : '0;
        mem_rd_data_i    <= mem_rd_en_o ? mem_ref(mem_rd_addr_o) : '0;
    end

    // every port pulse against what the stimulus expects
    always @(negedge clk_i) begin
        if (reset_i && core_reg_o.en) begin
            reg_pulses++;
            check_value("core_reg_o.we", core_reg_o.we, exp_we);
            check_value("core_reg_o.addr", core_reg_o.addr, exp_regno);
            if (exp_we) begin
                check_value("core_reg_o.wdata", core_reg_o.wdata, exp_wdata);
            end
        end
        if (reset_i && mem_rd_en_o) begin
            mem_pulses++;
            check_value("mem_rd_addr_o", mem_rd_addr_o, exp_mem_addr);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks and DMI access
    //////////////////////////////////////////////////////////////////////

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task report_timeout(input string what);
        error_count++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    // called on a falling edge, returns on a falling edge
    task dmi_access(input logic [1:0] op, input logic [6:0] addr, input logic [31:0] wdata,
                    output logic [31:0] data, output logic error);
        int cycles;
        data   = '0;
        error  = 1'b0;
        cycles = 0;
        if (timed_out) begin
            return;
        end
        while (!dmi_req_ready_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!dmi_req_ready_o) begin
            report_timeout("dmi_req_ready_o");
            return;
        end
        dmi_req_valid_i = 1'b1;
        dmi_req_i.op    = op;
        dmi_req_i.addr  = addr;
        dmi_req_i.data  = wdata;
        @(negedge clk_i);
        dmi_req_valid_i = 1'b0;
        cycles = 0;
        while (!dmi_resp_valid_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!dmi_resp_valid_o) begin
            report_timeout("dmi_resp_valid_o");
            return;
        end
        data  = dmi_resp_o.data;
        error = dmi_resp_o.error;
    endtask

    task dmi_read(input logic [6:0] addr, output logic [31:0] data);
        logic error;
        dmi_access(`DM_OP_READ, addr, '0, data, error);
        check_value("dmi_resp_o.error", error, 1'b0);
    endtask

    task dmi_write(input logic [6:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] resp_data;
        logic        error;
        dmi_access(`DM_OP_WRITE, addr, data, resp_data, error);
        check_value("dmi_resp_o.error", error, exp_err);
        check_value("dmi_resp_o.data", resp_data, '0);
    endtask

    task wait_run_req(input logic want_halt);
        int cycles;
        cycles = 0;
        if (timed_out) begin
            return;
        end
        while (!(want_halt ? core_halt_req_o : core_resume_req_o) && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (want_halt && !core_halt_req_o) begin
            report_timeout("core_halt_req_o");
        end else if (!want_halt && !core_resume_req_o) begin
            report_timeout("core_resume_req_o");
        end
    endtask

    task wait_dmstatus(input int bit_idx, input string what);
        logic [31:0] status;
        int          polls;
        polls = 0;
        dmi_read(`DM_ADDR_DMSTATUS, status);
        while (!timed_out && !status[bit_idx] && polls < WAIT_LIMIT) begin
            dmi_read(`DM_ADDR_DMSTATUS, status);
            polls++;
        end
        if (!timed_out && !status[bit_idx]) begin
            report_timeout(what);
        end
    endtask

    task wait_cmd_idle;
        logic [31:0] status;
        int          polls;
        polls = 0;
        dmi_read(`DM_ADDR_ABSTRACTCS, status);
        while (!timed_out && status[`DM_ABSTRACTCS_BUSY_BIT] && polls < WAIT_LIMIT) begin
            dmi_read(`DM_ADDR_ABSTRACTCS, status);
            polls++;
        end
        if (!timed_out && status[`DM_ABSTRACTCS_BUSY_BIT]) begin
            report_timeout("abstractcs.busy to clear");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed            = 64;
        error_count     = 0;
        check_count     = 0;
        timed_out       = 1'b0;
        reg_pulses      = 0;
        mem_pulses      = 0;
        exp_we          = 1'b0;
        exp_regno       = '0;
        exp_wdata       = '0;
        exp_mem_addr    = '0;
        reset_i         = 1'b0;
        dmi_req_valid_i = 1'b0;
        dmi_req_i       = '0;
        core_ebreak_i   = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            reg_table[i] = i * 32'h9E37_79B9 + 32'h0101_0101;
        end
        repeat (2) @(negedge clk_i);
        reset_i = 1'b1;
        @(negedge clk_i);

        // reset state
        check_value("dmi_req_ready_o", dmi_req_ready_o, 1'b1);
        check_value("dmi_resp_valid_o", dmi_resp_valid_o, 1'b0);
        check_value("core_halt_req_o", core_halt_req_o, 1'b0);
        check_value("core_resume_req_o", core_resume_req_o, 1'b0);
        check_value("core_reg_o.en", core_reg_o.en, 1'b0);
        check_value("mem_rd_en_o", mem_rd_en_o, 1'b0);
        dmi_read(`DM_ADDR_DMSTATUS, rdata);
        check_value("dmstatus.allrunning", rdata[`DM_DMSTATUS_ALLRUNNING_BIT], 1'b1);
        check_value("dmstatus.allhalted", rdata[`DM_DMSTATUS_ALLHALTED_BIT], 1'b0);
        dmi_access(`DM_OP_READ, `DM_ADDR_DATA1, '0, rdata, err);
        check_value("data1 read error", err, 1'b1);
        check_value("data1 read data", rdata, '0);
        dmi_write(`DM_ADDR_DATA0, 32'h1234_5678, 1'b1);
        dmi_read(`DM_ADDR_DATA0, rdata);
        check_value("data0", rdata, '0);

        // halt through haltreq
        dmi_write(`DM_ADDR_DMCONTROL, 32'h8000_0001, 1'b0);
        wait_run_req(1'b1);
        wait_dmstatus(`DM_DMSTATUS_ALLHALTED_BIT, "dmstatus.allhalted");

        // register read
        regno      = $random(seed);
        exp_we     = 1'b0;
        exp_regno  = regno;
        reg_pulses = 0;
        dmi_write(`DM_ADDR_COMMAND, {`DM_CMD_ACCESS_REG, 6'd0, 1'b1, 1'b0, regno}, 1'b0);
        wait_cmd_idle;
        check_value("register read en pulses", reg_pulses, 1);
        dmi_read(`DM_ADDR_DATA0, rdata);
        check_value("data0", rdata, expected_data0(1'b0, regno));

        // register write, then a second command while busy
        wval  = $random(seed);
        regno = $random(seed);
        dmi_write(`DM_ADDR_DATA0, wval, 1'b0);
        exp_we     = 1'b1;
        exp_regno  = regno;
        exp_wdata  = wval;
        reg_pulses = 0;
        dmi_write(`DM_ADDR_COMMAND, {`DM_CMD_ACCESS_REG, 6'd0, 1'b1, 1'b1, regno}, 1'b0);
        dmi_write(`DM_ADDR_COMMAND, {`DM_CMD_ACCESS_REG, 6'd0, 1'b1, 1'b1, regno}, 1'b1);
        wait_cmd_idle;
        check_value("register write en pulses", reg_pulses, 1);
        dmi_read(`DM_ADDR_DATA0, rdata);
        check_value("data0", rdata, wval);

        // memory read
        maddr = $random(seed);
        dmi_write(`DM_ADDR_DATA1, maddr, 1'b0);
        exp_mem_addr = maddr;
        mem_pulses   = 0;
        reg_pulses   = 0;
        dmi_write(`DM_ADDR_COMMAND, {`DM_CMD_ACCESS_MEM, 24'd0}, 1'b0);
        wait_cmd_idle;
        check_value("memory read enable pulses", mem_pulses, 1);
        check_value("register en pulses", reg_pulses, 0);
        dmi_read(`DM_ADDR_DATA0, rdata);
        check_value("data0", rdata, expected_data0(1'b1, maddr));

        // resume
        dmi_write(`DM_ADDR_DMCONTROL, 32'h4000_0001, 1'b0);
        wait_run_req(1'b0);
        wait_dmstatus(`DM_DMSTATUS_ALLRUNNING_BIT, "dmstatus.allrunning");
        dmi_read(`DM_ADDR_DMSTATUS, rdata);
        check_value("dmstatus.allrunning", rdata[`DM_DMSTATUS_ALLRUNNING_BIT], 1'b1);
        check_value("dmstatus.allresumeack", rdata[`DM_DMSTATUS_ALLRESUMEACK_BIT], 1'b1);
        check_value("core_halt_req_o", core_halt_req_o, 1'b0);

        // halt again through ebreak, haltreq is clear by now
        core_ebreak_i = 1'b1;
        @(negedge clk_i);
        core_ebreak_i = 1'b0;
        wait_run_req(1'b1);
        wait_dmstatus(`DM_DMSTATUS_ALLHALTED_BIT, "dmstatus.allhalted after ebreak");
        dmi_read(`DM_ADDR_DMSTATUS, rdata);
        check_value("dmstatus.allresumeack", rdata[`DM_DMSTATUS_ALLRESUMEACK_BIT], 1'b0);
        check_value("dmstatus.allrunning", rdata[`DM_DMSTATUS_ALLRUNNING_BIT], 1'b0);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/dm_pkg.sv
source/dm_dmi_regs.sv
source/dm_run_ctrl.sv
source/dm_abstract_cmd.sv
source/dm_top.sv
bench/dm_clock_gen.sv
bench/dm_tb.sv
